/* gb_bus_pkg.sv */
// Bus and memory width types for the CPU, download, ROM and cartridge RAM ports
`default_nettype none

package gb_bus_pkg;

	// CPU side --------------------
	typedef logic [15:0] cpu_addr_t;	// Full 64 KB CPU space
	typedef logic [7:0]  cpu_data_t;

	// Download stream, one 16-bit word per strobe
	typedef logic [24:0] dl_addr_t;		// Byte address
	typedef logic [15:0] dl_data_t;

	// External ROM, word wide
	typedef logic [21:0] rom_word_addr_t;	// 9 bank bits over CPU A13..A1
	typedef logic [15:0] rom_word_t;

	// Cartridge RAM, 16 banks of 8 KB
	typedef logic [16:0] cram_addr_t;
	localparam int unsigned CRAM_BYTES = 1 << 17;

	localparam cpu_data_t OPEN_BUS = 8'hFF;	// Floating data bus value

endpackage

`default_nettype wire

/* gb_cart_pkg.sv */
// Cartridge format types, MBC kind enum, header offsets, register windows and keys
`default_nettype none

package gb_cart_pkg;

	// Header field types --------------------
	typedef logic [7:0] hdr_byte_t;		// One raw header byte
	typedef logic [8:0] rom_bank_t;		// 16 KB ROM bank, MBC5 needs all 9 bits
	typedef logic [3:0] ram_bank_t;		// 8 KB RAM bank, up to 16 banks

	// Memory bank controller found in the header
	typedef enum logic [2:0] {
		mbc_none,	// 32 KB flat ROM
		mbc_1,
		mbc_2,		// 512 x 4 bit internal RAM
		mbc_3,		// RTC registers share the RAM window
		mbc_5
	} mbc_kind_t;

	// Header offsets --------------------
	// Byte addresses of 16-bit download words
	localparam int unsigned HDR_TYPE_ADDR = 'h146;	// Cart type byte in high half
	localparam int unsigned HDR_SIZE_ADDR = 'h148;	// RAM size code high, ROM size code low

	// Fallback for the odd 72/80/96 bank size codes
	localparam rom_bank_t ROM_SIZE_DEFAULT_MASK = 9'd127;

	// Register windows --------------------
	// Compared against CPU address bits 15 to 13
	localparam logic [2:0] WIN_RAM_ENABLE = 3'b000;	// 0x0000-0x1FFF
	localparam logic [2:0] WIN_ROM_BANK   = 3'b001;	// 0x2000-0x3FFF
	localparam logic [2:0] WIN_RAM_BANK   = 3'b010;	// 0x4000-0x5FFF, also RTC select
	localparam logic [2:0] WIN_MODE       = 3'b011;	// 0x6000-0x7FFF, MBC1 only
	localparam logic [2:0] WIN_CRAM       = 3'b101;	// 0xA000-0xBFFF cartridge RAM

	// Low nibble written to the enable window that opens RAM
	localparam logic [3:0] RAM_ENABLE_KEY = 4'hA;

endpackage

`default_nettype wire

/* cart_header_capture.sv */
// Header capture from the download stream with MBC kind and ROM/RAM mask decode
`default_nettype none
`timescale 1ns/1ps

module cart_header_capture (
	input  wire                     clk_sys,
	input  wire                     dl_wr,
	input  wire gb_bus_pkg::dl_addr_t dl_addr,
	input  wire gb_bus_pkg::dl_data_t dl_data,
	output gb_cart_pkg::mbc_kind_t  mbc_kind,
	output gb_cart_pkg::rom_bank_t  rom_mask,
	output gb_cart_pkg::ram_bank_t  ram_mask,
	output gb_cart_pkg::hdr_byte_t  ram_size_code
);

	gb_cart_pkg::hdr_byte_t type_code;	// 0x147
	gb_cart_pkg::hdr_byte_t rom_size_code;	// 0x148

	// Capture --------------------
	// Holds its value across reset, the header only changes with a new download
	always_ff @(posedge clk_sys) begin
		if (dl_wr) begin
			if (dl_addr == gb_bus_pkg::dl_addr_t'(gb_cart_pkg::HDR_TYPE_ADDR)) begin
				type_code <= dl_data[15:8];
			end
			if (dl_addr == gb_bus_pkg::dl_addr_t'(gb_cart_pkg::HDR_SIZE_ADDR)) begin
				ram_size_code <= dl_data[15:8];	// 0x149
				rom_size_code <= dl_data[7:0];
			end
		end
	end

	// Decode --------------------
	always_comb begin
		case (type_code) inside
			[8'd1:8'd3]:   mbc_kind = gb_cart_pkg::mbc_1;	// Plain, RAM, RAM+battery
			[8'd5:8'd6]:   mbc_kind = gb_cart_pkg::mbc_2;
			[8'd15:8'd19]: mbc_kind = gb_cart_pkg::mbc_3;	// With and without timer
			[8'd25:8'd30]: mbc_kind = gb_cart_pkg::mbc_5;	// Rumble variants included
			default:       mbc_kind = gb_cart_pkg::mbc_none;
		endcase
	end

	// Bank count minus one, so the mask mirrors small ROMs
	always_comb begin
		case (rom_size_code)
			8'd0:    rom_mask = 9'h001;	// 32 KB
			8'd1:    rom_mask = 9'h003;	// 64 KB
			8'd2:    rom_mask = 9'h007;
			8'd3:    rom_mask = 9'h00F;
			8'd4:    rom_mask = 9'h01F;	// 512 KB
			8'd5:    rom_mask = 9'h03F;
			8'd6:    rom_mask = 9'h07F;	// 2 MB
			8'd7:    rom_mask = 9'h0FF;
			8'd8:    rom_mask = 9'h1FF;	// 8 MB, MBC5 only
			default: rom_mask = gb_cart_pkg::ROM_SIZE_DEFAULT_MASK;
		endcase
	end

	// 2 KB and 8 KB parts are a single bank
	always_comb begin
		case (ram_size_code)
			8'd0, 8'd1, 8'd2: ram_mask = 4'h0;
			8'd3:             ram_mask = 4'h3;	// 32 KB
			default:          ram_mask = 4'hF;	// 128 KB
		endcase
	end

endmodule

`default_nettype wire

/* mbc_bank_registers.sv */
// MBC bank, mode, RTC select and RAM enable registers written through the ROM window
`default_nettype none
`timescale 1ns/1ps

module mbc_bank_registers (
	input  wire                         clk_sys,
	input  wire                         reset,
	input  wire                         reg_wr,		// One cycle pulse per CPU write
	input  wire gb_bus_pkg::cpu_addr_t  wr_addr,
	input  wire gb_bus_pkg::cpu_data_t  wr_data,
	input  wire gb_cart_pkg::mbc_kind_t mbc_kind,
	output gb_cart_pkg::rom_bank_t      rom_bank_reg,
	output gb_cart_pkg::ram_bank_t      ram_bank_reg,
	output logic                        mbc1_mode,
	output logic                        rtc_mode,
	output logic                        ram_enable
);

	logic is_mbc1;
	logic is_mbc3;
	logic is_mbc5;
	logic key_match;

	assign is_mbc1   = (mbc_kind == gb_cart_pkg::mbc_1);
	assign is_mbc3   = (mbc_kind == gb_cart_pkg::mbc_3);
	assign is_mbc5   = (mbc_kind == gb_cart_pkg::mbc_5);
	assign key_match = (wr_data[3:0] == gb_cart_pkg::RAM_ENABLE_KEY);	// Upper nibble ignored

	always_ff @(posedge clk_sys) begin
		if (reset) begin
			rom_bank_reg <= 9'd1;	// Bank 1 sits at 0x4000 out of reset
			ram_bank_reg <= 4'd0;
			mbc1_mode    <= 1'b0;
			rtc_mode     <= 1'b0;
			ram_enable   <= 1'b0;
		end else if (reg_wr) begin
			case (wr_addr[15:13])
				gb_cart_pkg::WIN_RAM_ENABLE: begin
					ram_enable <= key_match;	// Any other value locks RAM
				end
				gb_cart_pkg::WIN_ROM_BANK: begin
					if (is_mbc5) begin
						if (wr_addr[12]) begin
							rom_bank_reg[8] <= wr_data[0];	// 0x3000 high bit
						end else begin
							rom_bank_reg[7:0] <= wr_data;	// MBC5 may select bank 0
						end
					end else if (wr_data[6:0] == 7'd0) begin
						rom_bank_reg <= 9'd1;	// Bank 0 request maps to 1
					end else begin
						rom_bank_reg <= {2'b00, wr_data[6:0]};
					end
				end
				gb_cart_pkg::WIN_RAM_BANK: begin
					if (is_mbc3 && wr_data[3]) begin
						rtc_mode <= 1'b1;	// 0x08-0x0C select a clock register
					end else if (is_mbc5) begin
						ram_bank_reg <= wr_data[3:0];
					end else begin
						rtc_mode     <= 1'b0;	// Back to RAM, no effect outside MBC3
						ram_bank_reg <= {2'b00, wr_data[1:0]};
					end
				end
				gb_cart_pkg::WIN_MODE: begin
					if (is_mbc1) begin
						mbc1_mode <= wr_data[0];	// 1 lets bank2 reach the low half
					end
				end
				default: begin
				end
			endcase
		end
	end

endmodule

`default_nettype wire

/* mbc_address_map.sv */
// Combinational map from CPU address and bank registers to ROM word and RAM byte addresses
`default_nettype none
`timescale 1ns/1ps

module mbc_address_map (
	input  wire gb_bus_pkg::cpu_addr_t  cpu_addr,
	input  wire gb_cart_pkg::mbc_kind_t mbc_kind,
	input  wire gb_cart_pkg::rom_bank_t rom_bank_reg,
	input  wire gb_cart_pkg::ram_bank_t ram_bank_reg,
	input  wire                         mbc1_mode,
	input  wire gb_cart_pkg::rom_bank_t rom_mask,
	input  wire gb_cart_pkg::ram_bank_t ram_mask,
	output gb_bus_pkg::rom_word_addr_t  rom_addr,
	output gb_bus_pkg::cram_addr_t      cram_addr
);

	logic                   lower_half;	// 0x0000-0x3FFF, fixed bank area
	logic [1:0]             bank2;		// MBC1 upper bank bits
	logic [6:0]             mbc1_bank;
	gb_cart_pkg::rom_bank_t eff_bank;
	gb_cart_pkg::rom_bank_t rom_bank;
	gb_cart_pkg::ram_bank_t ram_bank;

	assign lower_half = (cpu_addr[15:14] == 2'b00);
	assign eff_bank   = lower_half ? 9'd0 : rom_bank_reg;

	// Mode 0 keeps the low half on bank 0
	assign bank2     = (lower_half && !mbc1_mode) ? 2'b00 : ram_bank_reg[1:0];
	assign mbc1_bank = {bank2, eff_bank[4:0]};

	// ROM bank --------------------
	always_comb begin
		case (mbc_kind)
			gb_cart_pkg::mbc_1:                     rom_bank = {2'b00, mbc1_bank & rom_mask[6:0]};
			gb_cart_pkg::mbc_2, gb_cart_pkg::mbc_3: rom_bank = {2'b00, eff_bank[6:0] & rom_mask[6:0]};
			gb_cart_pkg::mbc_5:                     rom_bank = eff_bank & rom_mask;
			default:                                rom_bank = {8'd0, cpu_addr[14]};	// Flat 32 KB
		endcase
	end

	// RAM bank --------------------
	always_comb begin
		case (mbc_kind)
			gb_cart_pkg::mbc_1:                     ram_bank = {2'b00, bank2} & ram_mask;
			gb_cart_pkg::mbc_3, gb_cart_pkg::mbc_5: ram_bank = ram_bank_reg & ram_mask;
			default:                                ram_bank = 4'd0;	// MBC2 and plain carts
		endcase
	end

	assign rom_addr  = {rom_bank, cpu_addr[13:1]};	// A0 picks the byte lane later
	assign cram_addr = {ram_bank, cpu_addr[12:0]};

endmodule

`default_nettype wire

/* cart_ram.sv */
// 128 KB synchronous cartridge RAM with enable gating, MBC2 nibble and MBC3 RTC read rules
`default_nettype none
`timescale 1ns/1ps

module cart_ram (
	input  wire                         clk_sys,
	input  wire                         wr_en,
	input  wire gb_bus_pkg::cram_addr_t cram_addr,
	input  wire gb_bus_pkg::cpu_data_t  wr_data,
	input  wire                         ram_enable,
	input  wire                         is_mbc2,
	input  wire                         rtc_mode,
	output gb_bus_pkg::cpu_data_t       rd_data
);

	gb_bus_pkg::cpu_data_t mem [0:gb_bus_pkg::CRAM_BYTES-1];
	gb_bus_pkg::cpu_data_t mem_q;	// Raw byte, one cycle after the address
	logic                  nibble_q;	// Read hit the MBC2 4-bit cells

	always_ff @(posedge clk_sys) begin
		if (wr_en && ram_enable) begin
			mem[cram_addr] <= wr_data;
		end
		mem_q    <= mem[cram_addr];
		nibble_q <= is_mbc2 && (cram_addr[12:9] == 4'd0);	// 0xA000-0xA1FF
	end

	// Read rules --------------------
	always_comb begin
		if (!ram_enable) begin
			rd_data = gb_bus_pkg::OPEN_BUS;	// Locked RAM floats
		end else if (rtc_mode) begin
			rd_data = 8'h00;	// Clock registers are not modelled
		end else if (nibble_q) begin
			rd_data = {4'hF, mem_q[3:0]};	// Upper nibble is not wired on MBC2
		end else begin
			rd_data = mem_q;
		end
	end

endmodule

`default_nettype wire

/* gb_cartridge.sv */
// Cartridge top: Wishbone classic slave FSM, read data select and cartridge submodules
`default_nettype none
`timescale 1ns/1ps

module gb_cartridge (
	input  wire                            clk_sys,
	input  wire                            reset,
	// Wishbone classic slave
	input  wire                            wb_cyc,
	input  wire                            wb_stb,
	input  wire                            wb_we,
	input  wire gb_bus_pkg::cpu_addr_t     wb_adr,
	input  wire gb_bus_pkg::cpu_data_t     wb_dat_w,
	output gb_bus_pkg::cpu_data_t          wb_dat_r,
	output logic                           wb_ack,
	// Download stream
	input  wire                            dl_wr,
	input  wire gb_bus_pkg::dl_addr_t      dl_addr,
	input  wire gb_bus_pkg::dl_data_t      dl_data,
	// External ROM, one cycle latency
	output gb_bus_pkg::rom_word_addr_t     rom_addr,
	input  wire gb_bus_pkg::rom_word_t     rom_data
);

	typedef enum logic [1:0] {
		st_idle,
		st_access,	// ROM and RAM fetch the addressed word
		st_ack		// Data valid, writes land on the closing edge
	} state_t;

	state_t                     state;
	logic                       ack_cycle;
	logic                       rom_win;
	logic                       cram_win;
	logic                       reg_wr;
	logic                       ram_wr;
	gb_cart_pkg::mbc_kind_t     mbc_kind;
	gb_cart_pkg::rom_bank_t     rom_mask;
	gb_cart_pkg::ram_bank_t     ram_mask;
	gb_cart_pkg::rom_bank_t     rom_bank_reg;
	gb_cart_pkg::ram_bank_t     ram_bank_reg;
	logic                       mbc1_mode;
	logic                       rtc_mode;
	logic                       ram_enable;
	gb_bus_pkg::cram_addr_t     cram_addr;
	gb_bus_pkg::cpu_data_t      ram_rd_data;

	cart_header_capture i_header (
		.clk_sys(clk_sys), .dl_wr(dl_wr), .dl_addr(dl_addr), .dl_data(dl_data),
		.mbc_kind(mbc_kind), .rom_mask(rom_mask), .ram_mask(ram_mask),
		.ram_size_code()	// Raw code only matters for save file sizing
	);

	mbc_bank_registers i_regs (
		.clk_sys(clk_sys), .reset(reset), .reg_wr(reg_wr), .wr_addr(wb_adr),
		.wr_data(wb_dat_w), .mbc_kind(mbc_kind), .rom_bank_reg(rom_bank_reg),
		.ram_bank_reg(ram_bank_reg), .mbc1_mode(mbc1_mode), .rtc_mode(rtc_mode),
		.ram_enable(ram_enable)
	);

	mbc_address_map i_map (
		.cpu_addr(wb_adr), .mbc_kind(mbc_kind), .rom_bank_reg(rom_bank_reg),
		.ram_bank_reg(ram_bank_reg), .mbc1_mode(mbc1_mode), .rom_mask(rom_mask),
		.ram_mask(ram_mask), .rom_addr(rom_addr), .cram_addr(cram_addr)
	);

	cart_ram i_cram (
		.clk_sys(clk_sys), .wr_en(ram_wr), .cram_addr(cram_addr), .wr_data(wb_dat_w),
		.ram_enable(ram_enable), .is_mbc2(mbc_kind == gb_cart_pkg::mbc_2),
		.rtc_mode(rtc_mode), .rd_data(ram_rd_data)
	);

	// Access FSM --------------------
	always_ff @(posedge clk_sys) begin
		if (reset) begin
			state <= st_idle;
		end else begin
			case (state)
				st_idle:   state <= (wb_cyc && wb_stb) ? st_access : st_idle;
				st_access: state <= (wb_cyc && wb_stb) ? st_ack : st_idle;	// Abandoned cycle
				default:   state <= st_idle;	// Ack lasts one cycle
			endcase
		end
	end

	assign rom_win   = !wb_adr[15];	// 0x0000-0x7FFF
	assign cram_win  = (wb_adr[15:13] == gb_cart_pkg::WIN_CRAM);
	assign ack_cycle = (state == st_ack) && wb_cyc && wb_stb;
	assign wb_ack    = ack_cycle;

	// Write strobes close on the acknowledging edge
	assign reg_wr = ack_cycle && wb_we && rom_win;
	assign ram_wr = ack_cycle && wb_we && cram_win;

	// Read data --------------------
	always_comb begin
		if (!ack_cycle) begin
			wb_dat_r = 8'h00;
		end else if (rom_win) begin
			wb_dat_r = wb_adr[0] ? rom_data[15:8] : rom_data[7:0];	// Odd byte is high lane
		end else if (cram_win) begin
			wb_dat_r = ram_rd_data;
		end else begin
			wb_dat_r = gb_bus_pkg::OPEN_BUS;	// VRAM and work RAM live elsewhere
		end
	end

endmodule

`default_nettype wire

/* gb_cartridge_asserts.sv */
// Wishbone handshake and ROM port assertions, bound into gb_cartridge
`default_nettype none
`timescale 1ns/1ps

module gb_cartridge_asserts (
	input wire                             clk_sys,
	input wire                             reset,
	input wire                             wb_cyc,
	input wire                             wb_stb,
	input wire                             wb_ack,
	input wire gb_bus_pkg::rom_word_addr_t rom_addr
);

	// Handshake --------------------
	ack_one_cycle: assert property (@(posedge clk_sys) disable iff (reset)
		wb_ack |=> !wb_ack)
		else $error("wb_ack held longer than one cycle");

	// Strobe seen on both access edges before the ack
	ack_needs_stb: assert property (@(posedge clk_sys) disable iff (reset)
		wb_ack |-> (wb_stb && $past(wb_stb) && $past(wb_stb, 2)))
		else $error("wb_ack without wb_stb held through the access");

	// Ack closes on the second edge after the one that sees wb_stb
	ack_latency: assert property (@(posedge clk_sys) disable iff (reset)
		$rose(wb_stb) |-> !wb_ack ##1 !wb_ack ##1 wb_ack)
		else $error("wb_ack not two cycles after wb_stb rose");

	// ROM port --------------------
	rom_addr_stable: assert property (@(posedge clk_sys) disable iff (reset)
		(wb_cyc && wb_stb && !wb_ack) |=> $stable(rom_addr))
		else $error("rom_addr moved during an access");

endmodule

bind gb_cartridge gb_cartridge_asserts i_asserts (
	.clk_sys(clk_sys), .reset(reset), .wb_cyc(wb_cyc), .wb_stb(wb_stb),
	.wb_ack(wb_ack), .rom_addr(rom_addr)
);

`default_nettype wire

/* tb_gb_cartridge.sv */
// Testbench for gb_cartridge: clock, reset, header download, ROM model, reference model, checks
`default_nettype none
`timescale 1ns/1ps

module tb_gb_cartridge;

	localparam int N_ROM_READS = 64;	// Test 1 reads per window
	localparam int N_ROUNDS    = 16;	// Bank rounds in tests 2 to 4
	localparam int N_RAM_BYTES = 8;		// Bytes per RAM round
	localparam int N_RESETS    = 7;
	localparam int N_ACCESSES  = 2 * N_ROM_READS + N_ROUNDS * (7 + 6 + 1 + 2 * N_RAM_BYTES)
		+ 3 * N_RAM_BYTES + 16;
	localparam int WATCHDOG_CYCLES = N_ACCESSES * 10 + N_RESETS * 16 + 100;

	logic                       clk_sys;
	logic                       reset;
	logic                       wb_cyc;
	logic                       wb_stb;
	logic                       wb_we;
	gb_bus_pkg::cpu_addr_t      wb_adr;
	gb_bus_pkg::cpu_data_t      wb_dat_w;
	gb_bus_pkg::cpu_data_t      wb_dat_r;
	logic                       wb_ack;
	logic                       dl_wr;
	gb_bus_pkg::dl_addr_t       dl_addr;
	gb_bus_pkg::dl_data_t       dl_data;
	gb_bus_pkg::rom_word_addr_t rom_addr;
	gb_bus_pkg::rom_word_t      rom_data = '0;

	// Reference model state
	gb_cart_pkg::mbc_kind_t     m_kind;
	gb_cart_pkg::rom_bank_t     m_rom_mask;
	gb_cart_pkg::ram_bank_t     m_ram_mask;
	gb_cart_pkg::rom_bank_t     m_rom_bank;
	gb_cart_pkg::ram_bank_t     m_ram_bank;
	logic                       m_mode;
	logic                       m_rtc;
	logic                       m_ram_en;
	gb_bus_pkg::cpu_data_t      model_ram [int];	// Only written cells exist
	gb_bus_pkg::cpu_addr_t      ram_addrs [N_RAM_BYTES];
	integer                     seed = 4;
	gb_bus_pkg::cpu_data_t      rd_byte;
	gb_bus_pkg::cpu_data_t      cfg;
	gb_bus_pkg::rom_word_t      bank1_word;

	gb_cartridge i_dut (
		.clk_sys(clk_sys), .reset(reset), .wb_cyc(wb_cyc), .wb_stb(wb_stb), .wb_we(wb_we),
		.wb_adr(wb_adr), .wb_dat_w(wb_dat_w), .wb_dat_r(wb_dat_r), .wb_ack(wb_ack),
		.dl_wr(dl_wr), .dl_addr(dl_addr), .dl_data(dl_data),
		.rom_addr(rom_addr), .rom_data(rom_data)
	);

	initial begin
		clk_sys = 1'b0;
		forever #50 clk_sys = ~clk_sys;	// 100 ns period
	end

	// ROM model --------------------
	function automatic gb_bus_pkg::rom_word_t rom_mix(input gb_bus_pkg::rom_word_addr_t a);
		return (a[15:0] ^ {a[21:16], a[21:12]}) ^ 16'h5A3C;	// Bank bits reach both bytes
	endfunction

	always @(posedge clk_sys) rom_data <= rom_mix(rom_addr);	// One cycle latency

	// Reference model --------------------
	function automatic gb_bus_pkg::rom_word_addr_t rom_index(input gb_bus_pkg::cpu_addr_t a);
		logic                   lower;
		logic [1:0]             b2;
		gb_cart_pkg::rom_bank_t eff;
		gb_cart_pkg::rom_bank_t bank;
		lower = (a[15:14] == 2'b00);
		eff   = lower ? 9'd0 : m_rom_bank;
		b2    = (lower && !m_mode) ? 2'b00 : m_ram_bank[1:0];	// MBC1 upper bits
		case (m_kind)
			gb_cart_pkg::mbc_1: bank = {2'b00, {b2, eff[4:0]} & m_rom_mask[6:0]};
			gb_cart_pkg::mbc_2, gb_cart_pkg::mbc_3: bank = {2'b00, eff[6:0] & m_rom_mask[6:0]};
			gb_cart_pkg::mbc_5: bank = eff & m_rom_mask;
			default: bank = {8'd0, a[14]};
		endcase
		return {bank, a[13:1]};
	endfunction

	function automatic gb_bus_pkg::cram_addr_t ram_index(input gb_bus_pkg::cpu_addr_t a);
		gb_cart_pkg::ram_bank_t bank;
		case (m_kind)
			gb_cart_pkg::mbc_1: bank = {2'b00, m_ram_bank[1:0]} & m_ram_mask;
			gb_cart_pkg::mbc_3, gb_cart_pkg::mbc_5: bank = m_ram_bank & m_ram_mask;
			default: bank = 4'd0;
		endcase
		return {bank, a[12:0]};
	endfunction

	function automatic gb_bus_pkg::cpu_data_t expected_read(input gb_bus_pkg::cpu_addr_t a);
		gb_bus_pkg::rom_word_t w;
		gb_bus_pkg::cpu_data_t b;
		if (!a[15]) begin
			w = rom_mix(rom_index(a));
			return a[0] ? w[15:8] : w[7:0];
		end else if (a[15:13] == 3'b101) begin
			if (!m_ram_en) return 8'hFF;
			if (m_rtc) return 8'h00;
			b = model_ram[int'(ram_index(a))];
			if (m_kind == gb_cart_pkg::mbc_2 && a[12:9] == 4'd0) return {4'hF, b[3:0]};
			return b;
		end
		return 8'hFF;	// Unmapped window
	endfunction

	task automatic model_write(input gb_bus_pkg::cpu_addr_t a, input gb_bus_pkg::cpu_data_t d);
		case (a[15:13])
			3'b000: m_ram_en = (d[3:0] == 4'hA);
			3'b001: begin
				if (m_kind == gb_cart_pkg::mbc_5) begin
					if (a[12]) m_rom_bank[8] = d[0];
					else m_rom_bank[7:0] = d;
				end else begin
					m_rom_bank = (d[6:0] == 7'd0) ? 9'd1 : {2'b00, d[6:0]};
				end
			end
			3'b010: begin
				if (m_kind == gb_cart_pkg::mbc_3) begin
					m_rtc = d[3];
					if (!d[3]) m_ram_bank = {2'b00, d[1:0]};
				end else if (m_kind == gb_cart_pkg::mbc_5) begin
					m_ram_bank = d[3:0];
				end else begin
					m_ram_bank = {2'b00, d[1:0]};
				end
			end
			3'b011: if (m_kind == gb_cart_pkg::mbc_1) m_mode = d[0];
			3'b101: if (m_ram_en) model_ram[int'(ram_index(a))] = d;	// Locked writes drop
			default: begin
			end
		endcase
	endtask

	task automatic model_reset();
		m_rom_bank = 9'd1;
		m_ram_bank = 4'd0;
		m_mode     = 1'b0;
		m_rtc      = 1'b0;
		m_ram_en   = 1'b0;
	endtask

	// Stimulus helpers --------------------
	function automatic gb_bus_pkg::cpu_data_t rand_byte();
		return gb_bus_pkg::cpu_data_t'($random(seed));
	endfunction

	function automatic gb_bus_pkg::cpu_addr_t rand_addr(input gb_bus_pkg::cpu_addr_t base,
			input gb_bus_pkg::cpu_addr_t span);
		return base | (gb_bus_pkg::cpu_addr_t'($random(seed)) & span);
	endfunction

	task automatic check(input string name, input gb_bus_pkg::cpu_data_t exp,
			input gb_bus_pkg::cpu_data_t act);
		if (act !== exp) begin
			$display("[ERROR] %s expected %02h actual %02h", name, exp, act);
			$display("RESULT: FAIL");
			$fatal(1, "%s read data mismatch", name);
		end
	endtask

	// Reset held 16 cycles with the header words streamed in meanwhile
	task load_cart(input gb_cart_pkg::hdr_byte_t type_code, input gb_cart_pkg::hdr_byte_t rom_code,
			input gb_cart_pkg::hdr_byte_t ram_code);
		int unsigned a;
		reset = 1'b1;
		for (int i = 0; i < 16; i++) begin
			a       = 32'h140 + 2 * i;
			dl_wr   = (i < 8);
			dl_addr = gb_bus_pkg::dl_addr_t'(a);
			if (a == gb_cart_pkg::HDR_TYPE_ADDR) dl_data = {type_code, 8'h00};
			else if (a == gb_cart_pkg::HDR_SIZE_ADDR) dl_data = {ram_code, rom_code};
			else dl_data = gb_bus_pkg::dl_data_t'(a * 3);	// Filler title bytes
			@(posedge clk_sys);
			#1;
		end
		dl_wr = 1'b0;
		reset = 1'b0;
		case (type_code) inside
			[8'd1:8'd3]:   m_kind = gb_cart_pkg::mbc_1;
			[8'd5:8'd6]:   m_kind = gb_cart_pkg::mbc_2;
			[8'd15:8'd19]: m_kind = gb_cart_pkg::mbc_3;
			[8'd25:8'd30]: m_kind = gb_cart_pkg::mbc_5;
			default:       m_kind = gb_cart_pkg::mbc_none;
		endcase
		if (rom_code == 8'd0) m_rom_mask = 9'd1;
		else if (rom_code <= 8'd8) m_rom_mask = gb_cart_pkg::rom_bank_t'((1 << (rom_code + 1)) - 1);
		else m_rom_mask = 9'd127;
		m_ram_mask = (ram_code <= 8'd2) ? 4'd0 : (ram_code == 8'd3) ? 4'd3 : 4'd15;
		model_reset();
	endtask

	task apply_reset();
		reset = 1'b1;
		repeat (16) begin
			@(posedge clk_sys);
			#1;
		end
		reset = 1'b0;
		model_reset();
	endtask

	// One Wishbone classic cycle, data sampled mid cycle while ack is high
	task bus_cycle(input logic we, input gb_bus_pkg::cpu_addr_t adr,
			input gb_bus_pkg::cpu_data_t dat, output gb_bus_pkg::cpu_data_t rd);
		wb_cyc   = 1'b1;
		wb_stb   = 1'b1;
		wb_we    = we;
		wb_adr   = adr;
		wb_dat_w = dat;
		@(negedge clk_sys);
		while (!wb_ack) @(negedge clk_sys);
		rd = wb_dat_r;
		@(posedge clk_sys);	// Acknowledging edge
		#1;
		wb_cyc = 1'b0;
		wb_stb = 1'b0;
		wb_we  = 1'b0;
		@(posedge clk_sys);	// Idle cycle between accesses
		#1;
	endtask

	task do_write(input gb_bus_pkg::cpu_addr_t adr, input gb_bus_pkg::cpu_data_t dat);
		gb_bus_pkg::cpu_data_t unused_rd;
		bus_cycle(1'b1, adr, dat, unused_rd);
		model_write(adr, dat);
	endtask

	task do_read(input string name, input gb_bus_pkg::cpu_addr_t adr);
		gb_bus_pkg::cpu_data_t rd;
		bus_cycle(1'b0, adr, 8'h00, rd);
		check(name, expected_read(adr), rd);
	endtask

	// Watchdog --------------------
	initial begin
		repeat (WATCHDOG_CYCLES) @(posedge clk_sys);
		$display("Timeout: the bus accesses did not finish in the expected run time");
		$display("RESULT: FAIL");
		$fatal(1, "watchdog expired");
	end

	// Tests --------------------
	initial begin
		reset    = 1'b1;
		wb_cyc   = 1'b0;
		wb_stb   = 1'b0;
		wb_we    = 1'b0;
		wb_adr   = '0;
		wb_dat_w = '0;
		dl_wr    = 1'b0;
		dl_addr  = '0;
		dl_data  = '0;
		@(posedge clk_sys);
		#1;

		load_cart(8'h00, 8'h00, 8'h00);	// Flat 32 KB, no MBC
		repeat (N_ROM_READS) do_read("no_mbc_rom", rand_addr(16'h0000, 16'h7FFF));
		repeat (N_ROM_READS / 2) do_read("unmapped_vram", rand_addr(16'h8000, 16'h1FFF));
		repeat (N_ROM_READS / 2) do_read("unmapped_high", rand_addr(16'hC000, 16'h3FFF));

		load_cart(8'h01, gb_cart_pkg::hdr_byte_t'($unsigned($random(seed)) % 7), 8'h00);
		for (int i = 0; i < N_ROUNDS; i++) begin
			do_write(rand_addr(16'h2000, 16'h1FFF), (i % 4 == 0) ? 8'h00 : rand_byte());
			do_write(rand_addr(16'h4000, 16'h1FFF), rand_byte());	// bank2
			do_write(rand_addr(16'h6000, 16'h1FFF), rand_byte());	// Mode select
			repeat (4) do_read("mbc1_rom", rand_addr(16'h0000, 16'h7FFF));
		end

		load_cart(8'h19, gb_cart_pkg::hdr_byte_t'($unsigned($random(seed)) % 9), 8'h00);
		for (int i = 0; i < N_ROUNDS; i++) begin
			do_write(rand_addr(16'h2000, 16'h0FFF), (i % 4 == 0) ? 8'h00 : rand_byte());
			do_write(rand_addr(16'h3000, 16'h0FFF), rand_byte());	// Bank bit 8
			repeat (4) do_read("mbc5_rom", rand_addr(16'h0000, 16'h7FFF));
		end

		// Banked RAM on MBC5, mask from a random size code
		load_cart(8'h1B, 8'h03, gb_cart_pkg::hdr_byte_t'($unsigned($random(seed)) % 6));
		repeat (4) do_read("ram_locked", rand_addr(16'hA000, 16'h1FFF));
		do_write(rand_addr(16'h0000, 16'h1FFF), 8'h0A | (rand_byte() & 8'hF0));
		for (int i = 0; i < N_ROUNDS; i++) begin
			do_write(rand_addr(16'h4000, 16'h1FFF), rand_byte());
			for (int j = 0; j < N_RAM_BYTES; j++) begin
				ram_addrs[j] = rand_addr(16'hA000, 16'h1FFF);
				do_write(ram_addrs[j], rand_byte());
			end
			for (int j = 0; j < N_RAM_BYTES; j++) do_read("ram_readback", ram_addrs[j]);
		end
		cfg = rand_byte();
		if (cfg[3:0] == 4'hA) cfg[3:0] = 4'h5;	// Anything but the key
		do_write(rand_addr(16'h0000, 16'h1FFF), cfg);
		for (int j = 0; j < 4; j++) do_read("ram_relocked", ram_addrs[j]);

		load_cart(8'h06, 8'h02, 8'h00);	// MBC2, 4 bit cells
		do_write(16'h0000, 8'h0A);
		for (int j = 0; j < N_RAM_BYTES; j++) begin
			ram_addrs[j] = rand_addr(16'hA000, 16'h01FF);
			do_write(ram_addrs[j], rand_byte());
		end
		for (int j = 0; j < N_RAM_BYTES; j++) do_read("mbc2_nibble", ram_addrs[j]);

		load_cart(8'h13, 8'h05, 8'h03);	// MBC3 with clock
		do_write(16'h0000, 8'h0A);
		do_write(16'h4000, 8'h08 | (rand_byte() & 8'h03));
		repeat (N_RAM_BYTES) do_read("mbc3_rtc", rand_addr(16'hA000, 16'h1FFF));

		// Second reset drops the bank and locks RAM
		do_write(16'h2000, 8'h05);
		do_write(16'h0000, 8'h0A);
		apply_reset();
		bank1_word = rom_mix(gb_bus_pkg::rom_word_addr_t'({9'd1, 13'd0}));
		bus_cycle(1'b0, 16'h4000, 8'h00, rd_byte);
		check("reset_rom_bank", bank1_word[7:0], rd_byte);
		bus_cycle(1'b0, 16'hA000, 8'h00, rd_byte);
		check("reset_ram_locked", 8'hFF, rd_byte);

		$display("RESULT: PASS");
		$finish;
	end

endmodule

`default_nettype wire

/* verilog.f */
gb_bus_pkg.sv
gb_cart_pkg.sv
cart_header_capture.sv
mbc_bank_registers.sv
mbc_address_map.sv
cart_ram.sv
gb_cartridge.sv
gb_cartridge_asserts.sv
tb_gb_cartridge.sv

/* Makefile */
# Verilator build and run for the cartridge testbench

VERILATOR ?= verilator
TOP       ?= tb_gb_cartridge
FILELIST  ?= verilog.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --timing --assert -j 0

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator and run the testbench"
	@echo "  clean  remove the build directory"
	@echo "  help   show this list"
	@echo "Variables: VERILATOR TOP FILELIST BUILD_DIR VFLAGS"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)
	./$(BUILD_DIR)/V$(TOP)

clean:
	rm -rf $(BUILD_DIR)
